// File: common/mpmc_pkg.sv
package mpmc_pkg;

	// ====================================================================
	// Sizes
	// ====================================================================

	// One app data strip is a single 16-byte word
	localparam int STRIP_BYTES = 16;
	localparam int STRIP_W = 128;
	localparam int ADDR_W = 32;
	localparam int APP_ADDR_W = 29;

	// Display is channel 0, CPU is channel 1
	localparam int NUM_CH = 2;
	localparam int CH_W = 1;

	localparam int CPU_W = 32;
	localparam int DISP_W = 128;

	// MIG app_cmd codes
	localparam logic [2:0] CMD_WRITE = 3'b000;
	localparam logic [2:0] CMD_READ = 3'b001;

	// ====================================================================
	// Sequencer states
	// ====================================================================
	typedef enum logic [3:0] {
		CALIB = 4'd0,
		IDLE = 4'd1,
		WRITE_DATA = 4'd2,
		WRITE_CMD = 4'd3,
		READ_CMD = 4'd4,
		READ_WAIT = 4'd5,
		DONE = 4'd6
	} seq_state_t;

	// ====================================================================
	// Request and response payloads
	// ====================================================================

	// Strip request as seen by the sequencer, mask bit high means byte kept
	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		logic [STRIP_BYTES-1:0] mask;
		logic [STRIP_W-1:0] data;
	} strip_req_t;

	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [CPU_W/8-1:0] sel;
		logic [CPU_W-1:0] dat;
	} cpu_req_t;

	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [DISP_W/8-1:0] sel;
		logic [DISP_W-1:0] dat;
	} disp_req_t;

	// Read data only, undefined for a write
	typedef struct packed {
		logic [CPU_W-1:0] dat;
	} cpu_rsp_t;

	typedef struct packed {
		logic [DISP_W-1:0] dat;
	} disp_rsp_t;

endpackage

// File: channel/mpmc_channel_port.sv
`timescale 1ns/1ps

module mpmc_channel_port #(
	parameter type REQ_T = mpmc_pkg::cpu_req_t,
	parameter type RSP_T = mpmc_pkg::cpu_rsp_t
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,

	// Request and response sides
	input  logic req_valid_i,
	output logic req_ready_o,
	input  REQ_T req_i,
	output logic rsp_valid_o,
	input  logic rsp_ready_i,
	output RSP_T rsp_o,

	// Prioritizer and sequencer side
	output logic pend_o,
	output mpmc_pkg::strip_req_t strip_o,
	input  logic grant_i,
	input  logic done_i,
	input  logic [mpmc_pkg::STRIP_W-1:0] rd_strip_i
);

	REQ_T req_q;
	RSP_T rsp_q;
	logic busy_q;
	logic pend_q;
	logic rsp_valid_q;

	// Channel width and lane position within the strip
	localparam int DW = $bits(req_q.dat);
	localparam int NB = DW / 8;
	localparam int OFF_W = $clog2(mpmc_pkg::STRIP_BYTES);
	localparam logic [OFF_W-1:0] LANE_MASK = OFF_W'(mpmc_pkg::STRIP_BYTES - NB);

	logic [OFF_W-1:0] lane_off;
	logic [mpmc_pkg::STRIP_BYTES-1:0] sel_strip;
	logic [mpmc_pkg::STRIP_W-1:0] dat_strip;
	logic [mpmc_pkg::STRIP_W-1:0] rd_shift;

	// ====================================================================
	// Lane placement
	// ====================================================================
	always_comb begin
		// Byte offset of this channel's lane, aligned to its width
		lane_off = req_q.adr[OFF_W-1:0] & LANE_MASK;

		sel_strip = '0;
		sel_strip[NB-1:0] = req_q.sel;
		sel_strip = sel_strip << lane_off;

		dat_strip = '0;
		dat_strip[DW-1:0] = req_q.dat;
		dat_strip = dat_strip << {lane_off, 3'b000};

		// Bytes outside the selects go out as all ones
		for (int b = 0; b < mpmc_pkg::STRIP_BYTES; b++) begin
			if (!sel_strip[b])
				dat_strip[b*8 +: 8] = 8'hff;
		end

		rd_shift = rd_strip_i >> {lane_off, 3'b000};
	end

	assign strip_o.we = req_q.we;
	assign strip_o.addr = {req_q.adr[mpmc_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
	assign strip_o.mask = ~sel_strip;
	assign strip_o.data = dat_strip;

	// ====================================================================
	// Handshake control
	// ====================================================================

	// One access in flight per channel
	assign req_ready_o = !busy_q;
	assign pend_o = pend_q;
	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o = rsp_q;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			busy_q <= 1'b0;
			pend_q <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			if (req_valid_i && req_ready_o) begin
				busy_q <= 1'b1;
				pend_q <= 1'b1;
			end else if (grant_i) begin
				pend_q <= 1'b0;
			end

			if (done_i) begin
				rsp_valid_q <= 1'b1;
			end else if (rsp_valid_q && rsp_ready_i) begin
				rsp_valid_q <= 1'b0;
				busy_q <= 1'b0;
			end
		end
	end

	// Request and read data holding
	always_ff @(posedge mem_ui_clk) begin
		if (req_valid_i && req_ready_o)
			req_q <= req_i;
		if (done_i)
			rsp_q.dat <= rd_shift[DW-1:0];
	end

endmodule

// File: design/mpmc_ch_prioritize.sv
`timescale 1ns/1ps

module mpmc_ch_prioritize (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,

	// Channel ports
	input  logic [mpmc_pkg::NUM_CH-1:0] pend_i,
	input  mpmc_pkg::strip_req_t [mpmc_pkg::NUM_CH-1:0] strip_i,
	output logic [mpmc_pkg::NUM_CH-1:0] grant_o,

	// Sequencer
	output logic seq_valid_o,
	input  logic seq_ready_i,
	output mpmc_pkg::strip_req_t seq_req_o,
	output logic [mpmc_pkg::CH_W-1:0] seq_ch_o
);

	logic lock_q;
	logic [mpmc_pkg::CH_W-1:0] lock_ch_q;
	logic [mpmc_pkg::CH_W-1:0] pick;
	logic [mpmc_pkg::CH_W-1:0] sel_ch;

	// Lowest pending channel wins, so the display comes first
	always_comb begin
		pick = '0;
		for (int i = mpmc_pkg::NUM_CH - 1; i >= 0; i--) begin
			if (pend_i[i])
				pick = i[mpmc_pkg::CH_W-1:0];
		end
	end

	// An offer the sequencer has not taken yet keeps its channel
	assign sel_ch = lock_q ? lock_ch_q : pick;

	assign seq_valid_o = pend_i[sel_ch];
	assign seq_req_o = strip_i[sel_ch];
	assign seq_ch_o = sel_ch;

	always_comb begin
		grant_o = '0;
		if (seq_valid_o && seq_ready_i)
			grant_o[sel_ch] = 1'b1;
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			lock_q <= 1'b0;
			lock_ch_q <= '0;
		end else if (seq_valid_o && !seq_ready_i) begin
			lock_q <= 1'b1;
			lock_ch_q <= sel_ch;
		end else if (seq_ready_i) begin
			lock_q <= 1'b0;
		end
	end

endmodule

// File: sequencer/mpmc_sequencer.sv
`timescale 1ns/1ps

module mpmc_sequencer (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,

	// From the prioritizer
	input  logic seq_valid_i,
	output logic seq_ready_o,
	input  mpmc_pkg::strip_req_t seq_req_i,
	input  logic [mpmc_pkg::CH_W-1:0] seq_ch_i,

	// Completion
	output logic done_o,
	output logic [mpmc_pkg::CH_W-1:0] done_ch_o,
	output logic [mpmc_pkg::STRIP_W-1:0] rd_strip_o,

	// MIG app port
	input  logic calib_complete_i,
	output logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr_o,
	output logic [2:0] app_cmd_o,
	output logic app_en_o,
	output logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data_o,
	output logic [mpmc_pkg::STRIP_BYTES-1:0] app_wdf_mask_o,
	output logic app_wdf_wren_o,
	output logic app_wdf_end_o,
	input  logic [mpmc_pkg::STRIP_W-1:0] app_rd_data_i,
	input  logic app_rd_data_valid_i,
	input  logic app_rdy_i,
	input  logic app_wdf_rdy_i
);

	mpmc_pkg::seq_state_t state;
	mpmc_pkg::seq_state_t state_nx;

	logic [mpmc_pkg::APP_ADDR_W-1:0] addr_q;
	logic [2:0] cmd_q;
	logic [mpmc_pkg::STRIP_W-1:0] wdf_data_q;
	logic [mpmc_pkg::STRIP_BYTES-1:0] wdf_mask_q;
	logic [mpmc_pkg::CH_W-1:0] ch_q;
	logic [mpmc_pkg::STRIP_W-1:0] rd_strip_q;

	// ====================================================================
	// State machine
	// ====================================================================
	always_comb begin
		state_nx = state;
		case (state)
			mpmc_pkg::CALIB: begin
				if (calib_complete_i)
					state_nx = mpmc_pkg::IDLE;
			end
			mpmc_pkg::IDLE: begin
				if (seq_valid_i) begin
					if (seq_req_i.we)
						state_nx = mpmc_pkg::WRITE_DATA;
					else
						state_nx = mpmc_pkg::READ_CMD;
				end
			end
			// Write data goes in ahead of the command
			mpmc_pkg::WRITE_DATA: begin
				if (app_wdf_rdy_i)
					state_nx = mpmc_pkg::WRITE_CMD;
			end
			mpmc_pkg::WRITE_CMD: begin
				if (app_rdy_i)
					state_nx = mpmc_pkg::DONE;
			end
			mpmc_pkg::READ_CMD: begin
				if (app_rdy_i)
					state_nx = mpmc_pkg::READ_WAIT;
			end
			mpmc_pkg::READ_WAIT: begin
				if (app_rd_data_valid_i)
					state_nx = mpmc_pkg::DONE;
			end
			mpmc_pkg::DONE: begin
				state_nx = mpmc_pkg::IDLE;
			end
			default: begin
				state_nx = mpmc_pkg::CALIB;
			end
		endcase
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst)
			state <= mpmc_pkg::CALIB;
		else
			state <= state_nx;
	end

	// ====================================================================
	// Access capture
	// ====================================================================

	// Strip and channel are taken on acceptance and held to the end
	always_ff @(posedge mem_ui_clk) begin
		if (state == mpmc_pkg::IDLE && seq_valid_i) begin
			addr_q <= seq_req_i.addr[mpmc_pkg::APP_ADDR_W-1:0];
			cmd_q <= seq_req_i.we ? mpmc_pkg::CMD_WRITE : mpmc_pkg::CMD_READ;
			wdf_data_q <= seq_req_i.data;
			wdf_mask_q <= seq_req_i.mask;
			ch_q <= seq_ch_i;
		end
		if (state == mpmc_pkg::READ_WAIT && app_rd_data_valid_i)
			rd_strip_q <= app_rd_data_i;
	end

	// ====================================================================
	// Outputs
	// ====================================================================
	assign seq_ready_o = (state == mpmc_pkg::IDLE);

	// Enables stay up with stable data until the controller takes them
	assign app_en_o = (state == mpmc_pkg::WRITE_CMD) || (state == mpmc_pkg::READ_CMD);
	assign app_addr_o = addr_q;
	assign app_cmd_o = cmd_q;

	// Single-strip writes, so every data beat is also the last
	assign app_wdf_wren_o = (state == mpmc_pkg::WRITE_DATA);
	assign app_wdf_end_o = (state == mpmc_pkg::WRITE_DATA);
	assign app_wdf_data_o = wdf_data_q;
	assign app_wdf_mask_o = wdf_mask_q;

	assign done_o = (state == mpmc_pkg::DONE);
	assign done_ch_o = ch_q;
	assign rd_strip_o = rd_strip_q;

endmodule

// File: design/mpmc_top.sv
`timescale 1ns/1ps

module mpmc_top (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,

	// CPU channel
	input  logic cpu_req_valid_i,
	output logic cpu_req_ready_o,
	input  mpmc_pkg::cpu_req_t cpu_req_i,
	output logic cpu_rsp_valid_o,
	input  logic cpu_rsp_ready_i,
	output mpmc_pkg::cpu_rsp_t cpu_rsp_o,

	// Display channel
	input  logic disp_req_valid_i,
	output logic disp_req_ready_o,
	input  mpmc_pkg::disp_req_t disp_req_i,
	output logic disp_rsp_valid_o,
	input  logic disp_rsp_ready_i,
	output mpmc_pkg::disp_rsp_t disp_rsp_o,

	// MIG app port
	input  logic calib_complete_i,
	output logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr_o,
	output logic [2:0] app_cmd_o,
	output logic app_en_o,
	output logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data_o,
	output logic [mpmc_pkg::STRIP_BYTES-1:0] app_wdf_mask_o,
	output logic app_wdf_wren_o,
	output logic app_wdf_end_o,
	input  logic [mpmc_pkg::STRIP_W-1:0] app_rd_data_i,
	input  logic app_rd_data_valid_i,
	input  logic app_rdy_i,
	input  logic app_wdf_rdy_i
);

	logic [mpmc_pkg::NUM_CH-1:0] pend;
	logic [mpmc_pkg::NUM_CH-1:0] grant;
	logic [mpmc_pkg::NUM_CH-1:0] port_done;
	mpmc_pkg::strip_req_t [mpmc_pkg::NUM_CH-1:0] strip;

	logic seq_valid;
	logic seq_ready;
	mpmc_pkg::strip_req_t seq_req;
	logic [mpmc_pkg::CH_W-1:0] seq_ch;

	logic seq_done;
	logic [mpmc_pkg::CH_W-1:0] done_ch;
	logic [mpmc_pkg::STRIP_W-1:0] rd_strip;

	// Completion goes only to the channel that issued the access
	assign port_done = {{(mpmc_pkg::NUM_CH-1){1'b0}}, seq_done} << done_ch;

	// ====================================================================
	// Channel ports
	// ====================================================================
	mpmc_channel_port #(
		.REQ_T(mpmc_pkg::disp_req_t),
		.RSP_T(mpmc_pkg::disp_rsp_t)
	) u_disp_port (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.req_valid_i(disp_req_valid_i),
		.req_ready_o(disp_req_ready_o),
		.req_i      (disp_req_i),
		.rsp_valid_o(disp_rsp_valid_o),
		.rsp_ready_i(disp_rsp_ready_i),
		.rsp_o      (disp_rsp_o),
		.pend_o     (pend[0]),
		.strip_o    (strip[0]),
		.grant_i    (grant[0]),
		.done_i     (port_done[0]),
		.rd_strip_i (rd_strip)
	);

	mpmc_channel_port #(
		.REQ_T(mpmc_pkg::cpu_req_t),
		.RSP_T(mpmc_pkg::cpu_rsp_t)
	) u_cpu_port (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.req_valid_i(cpu_req_valid_i),
		.req_ready_o(cpu_req_ready_o),
		.req_i      (cpu_req_i),
		.rsp_valid_o(cpu_rsp_valid_o),
		.rsp_ready_i(cpu_rsp_ready_i),
		.rsp_o      (cpu_rsp_o),
		.pend_o     (pend[1]),
		.strip_o    (strip[1]),
		.grant_i    (grant[1]),
		.done_i     (port_done[1]),
		.rd_strip_i (rd_strip)
	);

	// ====================================================================
	// Channel selection and app port sequencing
	// ====================================================================
	mpmc_ch_prioritize u_prio (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.pend_i     (pend),
		.strip_i    (strip),
		.grant_o    (grant),
		.seq_valid_o(seq_valid),
		.seq_ready_i(seq_ready),
		.seq_req_o  (seq_req),
		.seq_ch_o   (seq_ch)
	);

	mpmc_sequencer u_seq (
		.mem_ui_clk         (mem_ui_clk),
		.mem_ui_rst         (mem_ui_rst),
		.seq_valid_i        (seq_valid),
		.seq_ready_o        (seq_ready),
		.seq_req_i          (seq_req),
		.seq_ch_i           (seq_ch),
		.done_o             (seq_done),
		.done_ch_o          (done_ch),
		.rd_strip_o         (rd_strip),
		.calib_complete_i   (calib_complete_i),
		.app_addr_o         (app_addr_o),
		.app_cmd_o          (app_cmd_o),
		.app_en_o           (app_en_o),
		.app_wdf_data_o     (app_wdf_data_o),
		.app_wdf_mask_o     (app_wdf_mask_o),
		.app_wdf_wren_o     (app_wdf_wren_o),
		.app_wdf_end_o      (app_wdf_end_o),
		.app_rd_data_i      (app_rd_data_i),
		.app_rd_data_valid_i(app_rd_data_valid_i),
		.app_rdy_i          (app_rdy_i),
		.app_wdf_rdy_i      (app_wdf_rdy_i)
	);

endmodule

// File: bench/mig_model.sv
`timescale 1ns/1ps

module mig_model #(
	parameter int RD_LAT = 5
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,

	// Stall requests from the testbench
	input  logic rdy_stall_i,
	input  logic wdf_stall_i,

	// App port, seen from the controller side
	input  logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr_i,
	input  logic [2:0] app_cmd_i,
	input  logic app_en_i,
	input  logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data_i,
	input  logic [mpmc_pkg::STRIP_BYTES-1:0] app_wdf_mask_i,
	input  logic app_wdf_wren_i,
	input  logic app_wdf_end_i,
	output logic [mpmc_pkg::STRIP_W-1:0] app_rd_data_o,
	output logic app_rd_data_valid_o,
	output logic app_rdy_o,
	output logic app_wdf_rdy_o
);

	logic [mpmc_pkg::STRIP_W-1:0] mem [logic [mpmc_pkg::APP_ADDR_W-1:0]];
	logic [mpmc_pkg::STRIP_W-1:0] wbuf;
	logic [mpmc_pkg::STRIP_BYTES-1:0] wmask;
	logic [mpmc_pkg::APP_ADDR_W-1:0] rd_addr;
	int rd_cnt;

	// Contents of a strip never written, built from the whole address
	function automatic logic [mpmc_pkg::STRIP_W-1:0] fill_strip(
			input logic [mpmc_pkg::APP_ADDR_W-1:0] a);
		return {4{3'b101, a}};
	endfunction

	// Mask bit high keeps the stored byte
	function automatic logic [mpmc_pkg::STRIP_W-1:0] merge_strip(
			input logic [mpmc_pkg::STRIP_W-1:0] old,
			input logic [mpmc_pkg::STRIP_W-1:0] data,
			input logic [mpmc_pkg::STRIP_BYTES-1:0] mask);
		logic [mpmc_pkg::STRIP_W-1:0] res;
		res = old;
		for (int b = 0; b < mpmc_pkg::STRIP_BYTES; b++) begin
			if (!mask[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	assign app_rdy_o = !rdy_stall_i;
	assign app_wdf_rdy_o = !wdf_stall_i;

	// Handshakes are taken on the rising edge
	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			rd_cnt <= 0;
		end else begin
			if (app_wdf_wren_i && app_wdf_end_i && app_wdf_rdy_o) begin
				wbuf <= app_wdf_data_i;
				wmask <= app_wdf_mask_i;
			end
			if (app_en_i && app_rdy_o) begin
				if (app_cmd_i == mpmc_pkg::CMD_WRITE) begin
					mem[app_addr_i] = merge_strip(mem.exists(app_addr_i) ?
						mem[app_addr_i] : fill_strip(app_addr_i), wbuf, wmask);
				end else begin
					rd_addr <= app_addr_i;
					rd_cnt <= RD_LAT;
				end
			end else if (rd_cnt > 0) begin
				rd_cnt <= rd_cnt - 1;
			end
		end
	end

	// Read data goes out on the falling edge, one cycle wide
	always @(negedge mem_ui_clk) begin
		app_rd_data_valid_o <= (rd_cnt == 1);
		if (rd_cnt == 1)
			app_rd_data_o <= mem.exists(rd_addr) ? mem[rd_addr] : fill_strip(rd_addr);
	end

endmodule

// File: bench/tb_mpmc.sv
`timescale 1ns/1ps

module tb_mpmc;

	localparam logic DISP = 1'b0;
	localparam logic CPU = 1'b1;
	localparam int CYCLES_PER_TEST = 200;

	typedef struct packed {
		logic ch;
		logic we;
		logic pair;
		logic [31:0] adr;
		logic [15:0] sel;
		logic [127:0] dat;
		logic [127:0] exp;
	} entry_t;

	logic mem_ui_clk;
	logic mem_ui_rst;
	logic cpu_req_valid;
	logic cpu_req_ready;
	mpmc_pkg::cpu_req_t cpu_req;
	logic cpu_rsp_valid;
	logic cpu_rsp_ready;
	mpmc_pkg::cpu_rsp_t cpu_rsp;
	logic disp_req_valid;
	logic disp_req_ready;
	mpmc_pkg::disp_req_t disp_req;
	logic disp_rsp_valid;
	logic disp_rsp_ready;
	mpmc_pkg::disp_rsp_t disp_rsp;

	logic calib_complete;
	logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr;
	logic [2:0] app_cmd;
	logic app_en;
	logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data;
	logic [mpmc_pkg::STRIP_BYTES-1:0] app_wdf_mask;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic [mpmc_pkg::STRIP_W-1:0] app_rd_data;
	logic app_rd_data_valid;
	logic app_rdy;
	logic app_wdf_rdy;
	logic rdy_stall;
	logic wdf_stall;

	entry_t stim[$];
	logic [7:0] ref_bytes [logic [31:0]];
	bit stim_built;
	int tests;
	int checks;
	int errors;

	mpmc_top DUT (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cpu_req_valid_i(cpu_req_valid), .cpu_req_ready_o(cpu_req_ready),
		.cpu_req_i(cpu_req), .cpu_rsp_valid_o(cpu_rsp_valid),
		.cpu_rsp_ready_i(cpu_rsp_ready), .cpu_rsp_o(cpu_rsp),
		.disp_req_valid_i(disp_req_valid), .disp_req_ready_o(disp_req_ready),
		.disp_req_i(disp_req), .disp_rsp_valid_o(disp_rsp_valid),
		.disp_rsp_ready_i(disp_rsp_ready), .disp_rsp_o(disp_rsp),
		.calib_complete_i(calib_complete), .app_addr_o(app_addr), .app_cmd_o(app_cmd),
		.app_en_o(app_en), .app_wdf_data_o(app_wdf_data), .app_wdf_mask_o(app_wdf_mask),
		.app_wdf_wren_o(app_wdf_wren), .app_wdf_end_o(app_wdf_end),
		.app_rd_data_i(app_rd_data), .app_rd_data_valid_i(app_rd_data_valid),
		.app_rdy_i(app_rdy), .app_wdf_rdy_i(app_wdf_rdy)
	);

	mig_model u_mig (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.rdy_stall_i(rdy_stall), .wdf_stall_i(wdf_stall),
		.app_addr_i(app_addr), .app_cmd_i(app_cmd), .app_en_i(app_en),
		.app_wdf_data_i(app_wdf_data), .app_wdf_mask_i(app_wdf_mask),
		.app_wdf_wren_i(app_wdf_wren), .app_wdf_end_i(app_wdf_end),
		.app_rd_data_o(app_rd_data), .app_rd_data_valid_o(app_rd_data_valid),
		.app_rdy_o(app_rdy), .app_wdf_rdy_o(app_wdf_rdy)
	);

	initial begin
		mem_ui_clk = 1'b0;
		forever #50 mem_ui_clk = ~mem_ui_clk;
	end

	// ====================================================================
	// Helpers
	// ====================================================================
	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "error");
	endtask

	// Table entry with its expected read data from the byte reference
	task automatic add_entry(input logic ch, input logic we, input logic pair,
			input logic [31:0] adr, input logic [15:0] sel, input logic [127:0] dat);
		entry_t e;
		logic [31:0] base;
		int nb;
		base = {adr[31:4], 4'h0};
		nb = 16;
		// CPU word lanes sit at the word offset within the strip
		if (ch == CPU) begin
			base = base + {28'h0, adr[3:2], 2'b00};
			nb = 4;
		end
		e.ch = ch;
		e.we = we;
		e.pair = pair;
		e.adr = adr;
		e.sel = sel;
		e.dat = dat;
		e.exp = '0;
		for (int k = 0; k < nb; k++) begin
			if (we && sel[k])
				ref_bytes[base + k] = dat[k*8 +: 8];
			else if (!we && ref_bytes.exists(base + k))
				e.exp[k*8 +: 8] = ref_bytes[base + k];
		end
		stim.push_back(e);
	endtask

	function automatic logic req_ready(input logic ch);
		return ch ? cpu_req_ready : disp_req_ready;
	endfunction

	function automatic logic rsp_valid(input logic ch);
		return ch ? cpu_rsp_valid : disp_rsp_valid;
	endfunction

	function automatic logic [127:0] rsp_data(input logic ch);
		return ch ? {96'h0, cpu_rsp.dat} : disp_rsp.dat;
	endfunction

	task automatic drive_req(input entry_t e, input logic valid);
		if (e.ch == CPU) begin
			cpu_req.we = e.we;
			cpu_req.adr = e.adr;
			cpu_req.sel = e.sel[3:0];
			cpu_req.dat = e.dat[31:0];
			cpu_req_valid = valid;
		end else begin
			disp_req.we = e.we;
			disp_req.adr = e.adr;
			disp_req.sel = e.sel;
			disp_req.dat = e.dat;
			disp_req_valid = valid;
		end
	endtask

	task automatic set_rsp_ready(input logic ch, input logic v);
		if (ch == CPU)
			cpu_rsp_ready = v;
		else
			disp_rsp_ready = v;
	endtask

	// One full access, returns the time its response transferred
	task automatic run_access(input int idx, output time xfer_t);
		entry_t e;
		logic [127:0] first;
		int hold;
		e = stim[idx];
		@(negedge mem_ui_clk);
		drive_req(e, 1'b1);
		while (!req_ready(e.ch))
			@(negedge mem_ui_clk);
		@(negedge mem_ui_clk);
		drive_req(e, 1'b0);
		while (!rsp_valid(e.ch))
			@(negedge mem_ui_clk);
		first = rsp_data(e.ch);
		// Hold the response off for a random time
		hold = int'($urandom_range(3, 0));
		repeat (hold) begin
			@(negedge mem_ui_clk);
			check_value({127'h0, rsp_valid(e.ch)}, 128'h1, "response valid dropped while held");
			check_value(rsp_data(e.ch), first, "response changed while held");
		end
		set_rsp_ready(e.ch, 1'b1);
		@(negedge mem_ui_clk);
		set_rsp_ready(e.ch, 1'b0);
		xfer_t = $time;
		if (!e.we)
			check_value(first, e.exp, $sformatf("read data at %h", e.adr));
	endtask

	// Masked write lanes carry all-ones data
	always @(negedge mem_ui_clk) begin
		if (!mem_ui_rst && app_wdf_wren) begin
			for (int b = 0; b < mpmc_pkg::STRIP_BYTES; b++) begin
				if (app_wdf_mask[b])
					check_value({120'h0, app_wdf_data[b*8 +: 8]}, {120'h0, 8'hff},
						$sformatf("masked write lane %0d data", b));
			end
		end
	end

	// ====================================================================
	// Main sequence
	// ====================================================================
	initial begin
		int i;
		int errs_before;
		time t_disp;
		time t_cpu;
		logic [127:0] rnd;
		void'($urandom(32'hb337));
		mem_ui_rst = 1'b1;
		calib_complete = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		cpu_rsp_ready = 1'b0;
		disp_req_valid = 1'b0;
		disp_req = '0;
		disp_rsp_ready = 1'b0;
		rdy_stall = 1'b0;
		wdf_stall = 1'b0;
		tests = 0;
		checks = 0;
		errors = 0;

		// App port stalls for the whole run
		fork
			forever begin
				@(negedge mem_ui_clk);
				rdy_stall = ($urandom_range(3, 0) == 0);
				wdf_stall = ($urandom_range(3, 0) == 0);
			end
		join_none

		add_entry(CPU, 1'b1, 1'b0, 32'h0000_0100, 16'h000f, 128'h1122_3344);
		add_entry(CPU, 1'b0, 1'b0, 32'h0000_0100, 16'h0000, 128'h0);
		add_entry(DISP, 1'b1, 1'b0, 32'h0000_0200, 16'hffff,
			128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff);
		add_entry(DISP, 1'b0, 1'b0, 32'h0000_0200, 16'h0000, 128'h0);
		add_entry(CPU, 1'b1, 1'b0, 32'h0000_0208, 16'h0006, 128'ha5c3_e1f0);
		add_entry(DISP, 1'b0, 1'b0, 32'h0000_0200, 16'h0000, 128'h0);
		add_entry(CPU, 1'b0, 1'b0, 32'h0000_020c, 16'h0000, 128'h0);
		rnd = {$urandom, $urandom, $urandom, $urandom};
		add_entry(DISP, 1'b1, 1'b0, 32'h0000_0300, 16'hffff, rnd);
		add_entry(CPU, 1'b1, 1'b0, 32'h0000_0104, 16'h000f, 128'hdead_beef);
		// Display and CPU reads issued on the same edge
		add_entry(DISP, 1'b0, 1'b1, 32'h0000_0300, 16'h0000, 128'h0);
		add_entry(CPU, 1'b0, 1'b0, 32'h0000_0104, 16'h0000, 128'h0);
		rnd = {$urandom, $urandom, $urandom, $urandom};
		add_entry(DISP, 1'b1, 1'b0, 32'h0000_0500, 16'hffff, rnd);
		add_entry(CPU, 1'b1, 1'b0, 32'h0000_050c, 16'h0009, 128'h7788_99aa);
		add_entry(CPU, 1'b0, 1'b0, 32'h0000_0504, 16'h0000, 128'h0);
		add_entry(DISP, 1'b0, 1'b0, 32'h0000_0500, 16'h0000, 128'h0);
		stim_built = 1'b1;

		repeat (4) @(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;
		repeat (2) @(negedge mem_ui_clk);
		calib_complete = 1'b1;
		repeat (2) @(negedge mem_ui_clk);

		errs_before = errors;
		check_value({127'h0, cpu_req_ready}, 128'h1, "CPU request ready after reset");
		check_value({127'h0, disp_req_ready}, 128'h1, "display request ready after reset");
		check_value({127'h0, cpu_rsp_valid}, 128'h0, "CPU response valid after reset");
		check_value({127'h0, disp_rsp_valid}, 128'h0, "display response valid after reset");
		check_value({127'h0, app_en}, 128'h0, "app_en after reset");
		check_value({127'h0, app_wdf_wren}, 128'h0, "app_wdf_wren after reset");
		check_value({127'h0, app_wdf_end}, 128'h0, "app_wdf_end after reset");
		report_test("reset state", errs_before);

		i = 0;
		while (i < stim.size()) begin
			errs_before = errors;
			if (stim[i].pair) begin
				fork
					run_access(i, t_disp);
					run_access(i + 1, t_cpu);
				join
				check_value({127'h0, t_disp <= t_cpu}, 128'h1,
					"display response transferred after CPU response");
				report_test($sformatf("same-edge reads %h and %h", stim[i].adr,
					stim[i + 1].adr), errs_before);
				i = i + 2;
			end else begin
				run_access(i, t_cpu);
				report_test($sformatf("%s %s %h", stim[i].ch ? "cpu" : "disp",
					stim[i].we ? "write" : "read", stim[i].adr), errs_before);
				i = i + 1;
			end
		end

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized by the table length
	initial begin
		wait (stim_built);
		repeat (stim.size() * CYCLES_PER_TEST) @(posedge mem_ui_clk);
		$display("Timeout: the tests did not finish within %0d cycles, the DUT appears hung",
			stim.size() * CYCLES_PER_TEST);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: all.f
common/mpmc_pkg.sv
channel/mpmc_channel_port.sv
design/mpmc_ch_prioritize.sv
sequencer/mpmc_sequencer.sv
design/mpmc_top.sv
bench/mig_model.sv
bench/tb_mpmc.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/1ps -Mdir obj_dir
TOP ?= tb_mpmc
FILELIST ?= all.f
PASS_MSG = All checks passed

SIM = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
